// ==== bench/tftBoardTop_properties.sv ====
`timescale 1ns/10ps

module tftBoardTop_properties (
  input logic hwclk,
  input logic reset,
  input logic cyc,
  input logic stb,
  input logic ack,
  input logic chipSelect,
  input logic sclk,
  input logic busy
);

  // read back by the testbench at the end of the run
  int failCount = 0;

  // ack is a single cycle pulse
  ackOneCycle: assert property (@(posedge hwclk) disable iff (!reset) ack |=> !ack)
    else begin
      $error("wishbone ack held longer than one cycle");
      failCount++;
    end

  // ack only answers a live request
  ackAfterStb: assert property (@(posedge hwclk) disable iff (!reset) ack |-> $past(cyc && stb))
    else begin
      $error("wishbone ack without a preceding cyc and stb");
      failCount++;
    end

  // serial clock parked while deselected
  sclkIdle: assert property (@(posedge hwclk) disable iff (!reset) chipSelect |-> !sclk)
    else begin
      $error("sclk high while chip select is high");
      failCount++;
    end

  // frame stays open until busy drops
  csHeld: assert property (@(posedge hwclk) disable iff (!reset)
    (busy && !chipSelect) |=> (!chipSelect || !busy))
    else begin
      $error("chip select rose while busy");
      failCount++;
    end

endmodule

// bus side, SPI inputs parked at idle
bind wbSram tftBoardTop_properties u_busProps (
  .hwclk(hwclk), .reset(reset), .cyc(req_i.cyc), .stb(req_i.stb), .ack(ack_o),
  .chipSelect(1'b1), .sclk(1'b0), .busy(1'b0));

// SPI side, bus inputs parked at idle
bind spiTftSerializer tftBoardTop_properties u_spiProps (
  .hwclk(hwclk), .reset(reset), .cyc(1'b0), .stb(1'b0), .ack(1'b0),
  .chipSelect(chipSelect_o), .sclk(sclk_o), .busy(busy_o));

// ==== bench/tftBoardTop_tb.sv ====
`timescale 1ns/10ps

module tftBoardTop_tb;

  import tftPkg::*;

  logic        hwclk;
  logic        reset;
  logic [20:0] pb;
  logic [7:0]  left;
  logic [7:0]  right;
  logic        red, green, blue;
  logic [7:0]  rxdata;
  logic        rxready;
  logic        txready;
  logic [63:0] segs;
  logic [7:0]  txdata;
  logic        txclk, rxclk;

  // stimulus table, one playback per row
  int          rowLen [3];
  cmdWord_t    rowWords [3][8];
  logic [31:0] lcgState;

  // SPI receiver model state
  logic     sclkPrev = 1'b0;
  logic     csPrev = 1'b1;
  int       bitCount = 0;
  int       frames = 0;
  cmdWord_t shiftIn = '0;
  cmdWord_t rxWords [$];

  tftBoardTop #(.divideRatio(4)) u_tftBoardTop (
    .hwclk(hwclk), .reset(reset), .pb(pb), .left(left), .right(right),
    .ss7(segs[63:56]), .ss6(segs[55:48]), .ss5(segs[47:40]), .ss4(segs[39:32]),
    .ss3(segs[31:24]), .ss2(segs[23:16]), .ss1(segs[15:8]), .ss0(segs[7:0]),
    .red(red), .green(green), .blue(blue), .txdata(txdata), .rxdata(rxdata),
    .txclk(txclk), .rxclk(rxclk), .txready(txready), .rxready(rxready));

  always #10 hwclk = ~hwclk;

  function automatic logic [31:0] nextRandom(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic abortRun(input string why);
    $display("Error: %s", why);
    $display("Done: errors found");
    $fatal(1, "run aborted");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (expected == actual) else begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      $display("Done: errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  // one rxready strobe per byte
  task automatic sendByte(input logic [7:0] b);
    @(posedge hwclk);
    #1 rxdata = b;
    rxready = 1'b1;
    @(posedge hwclk);
    #1 rxready = 1'b0;
  endtask

  // right[0] pulses when the SRAM write is acked
  task automatic loadWord(input cmdWord_t w);
    int cycles;
    sendByte(w[15:8]);
    sendByte(w[7:0]);
    cycles = 0;
    do begin
      @(negedge hwclk);
      cycles++;
    end while (!right[0] && cycles < 20);
    if (!right[0]) abortRun("loader write was never acknowledged");
  endtask

  task automatic pressStart();
    @(posedge hwclk);
    #1 pb[0] = 1'b1;
    @(posedge hwclk);
    #1 pb[0] = 1'b0;
  endtask

  task automatic waitBusy();
    int cycles;
    cycles = 0;
    do begin
      @(negedge hwclk);
      cycles++;
    end while (!right[7] && cycles < 200);
    if (!right[7]) abortRun("serializer never became busy");
  endtask

  task automatic waitDone();
    int cycles;
    cycles = 0;
    do begin
      @(negedge hwclk);
      cycles++;
    end while (!green && cycles < 5000);
    if (!green) abortRun("playback never reached done");
  endtask

  // samples bitData on rising sclk inside a frame
  always @(negedge hwclk) begin
    if (!right[3] && csPrev) begin
      frames++;
      bitCount = 0;
    end
    if (!right[3] && right[2] && !sclkPrev) begin
      shiftIn = {shiftIn[14:0], right[1]};
      bitCount++;
      if (bitCount == 16) rxWords.push_back(shiftIn);
    end
    if (right[3] && !csPrev) checkValue("bits per frame", 16, bitCount);
    sclkPrev = right[2];
    csPrev = right[3];
  end

  // protocol failures end the run at once
  always @(negedge hwclk) begin
    if (u_tftBoardTop.u_wbSram.u_busProps.failCount != 0 ||
        u_tftBoardTop.u_spiTftSerializer.u_spiProps.failCount != 0) begin
      abortRun("bus or SPI protocol assertion failed");
    end
  end

  initial begin
    hwclk = 1'b0;
    reset = 1'b0;
    pb = '0;
    rxdata = '0;
    rxready = 1'b0;
    txready = 1'b0;
    // fixed words, empty list, random words
    rowLen = '{3, 0, 6};
    rowWords[0][0] = 16'h2A00;
    rowWords[0][1] = 16'h00EF;
    rowWords[0][2] = 16'hC35A;
    lcgState = 32'd73719;
    for (int i = 0; i < 6; i++) begin
      lcgState = nextRandom(lcgState);
      rowWords[2][i] = lcgState[31:16];
    end
    repeat (16) @(posedge hwclk);
    #1 reset = 1'b1;
    @(negedge hwclk);
    checkValue("reset chip select", 1, right[3]);
    checkValue("reset sclk", 0, right[2]);
    checkValue("reset busy", 0, right[7]);
    checkValue("reset done", 0, green);
    checkValue("reset overrun", 0, red);
    checkValue("reset count", 0, left);
    // seven segment, UART transmit, blue and spare right LEDs stay low
    checkValue("tied off outputs", 0,
               {|segs, |txdata, txclk, rxclk, blue, |right[6:4]});
    for (int r = 0; r < 3; r++) begin
      // word 0 is the length, always written at address 0
      loadWord(cmdWord_t'(rowLen[r]));
      for (int i = 0; i < rowLen[r]; i++) begin
        loadWord(rowWords[r][i]);
      end
      rxWords.delete();
      frames = 0;
      pressStart();
      @(negedge hwclk);
      checkValue($sformatf("row %0d overrun cleared", r), 0, red);
      checkValue($sformatf("row %0d done cleared", r), 0, green);
      if (r == 0) begin
        // stray byte while the first word shifts
        waitBusy();
        sendByte(8'h5A);
        @(negedge hwclk);
        checkValue("overrun set", 1, red);
      end
      waitDone();
      checkValue($sformatf("row %0d frames", r), rowLen[r], frames);
      checkValue($sformatf("row %0d sent count", r), rowLen[r], left);
      checkValue($sformatf("row %0d words received", r), rowLen[r], rxWords.size());
      for (int i = 0; i < rowLen[r]; i++) begin
        checkValue($sformatf("row %0d word %0d", r, i), rowWords[r][i], rxWords[i]);
      end
    end
    repeat (4) @(posedge hwclk);
    // bound protocol checks count their own failures
    if (u_tftBoardTop.u_wbSram.u_busProps.failCount == 0 &&
        u_tftBoardTop.u_spiTftSerializer.u_spiProps.failCount == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Error: bus or SPI protocol assertion failed");
      $display("Done: errors found");
      $fatal(1, "protocol failure");
    end
  end

endmodule

// ==== design/byteLoader.sv ====
`timescale 1ns/10ps

module byteLoader (
  input  logic             hwclk,
  input  logic             reset,
  input  logic             rxReady_i,
  input  logic [7:0]       rxData_i,
  input  logic             restart_i,
  input  logic             accept_i,
  input  logic             ack_i,
  output logic             loadReq_o,
  output tftPkg::busReq_t  req_o,
  output logic             loadDone_o,
  output logic             overrun_o
);

  import tftPkg::*;

  logic      haveHigh;
  logic      pending;
  logic [7:0] highByte;
  sramAddr_t addr;
  cmdWord_t  wordReg;

  always_ff @(posedge hwclk, negedge reset) begin
    if (!reset) begin
      haveHigh  <= 1'b0;
      pending   <= 1'b0;
      addr      <= '0;
      overrun_o <= 1'b0;
    end else if (restart_i) begin
      // new playback, next list loads from word 0
      haveHigh  <= 1'b0;
      pending   <= 1'b0;
      addr      <= '0;
      overrun_o <= 1'b0;
    end else begin
      if (rxReady_i && !accept_i) begin
        // byte during playback is lost
        overrun_o <= 1'b1;
      end else if (rxReady_i) begin
        haveHigh <= !haveHigh;
        // second byte completes the word
        if (haveHigh) begin
          pending <= 1'b1;
        end
      end
      if (pending && ack_i) begin
        pending <= 1'b0;
        addr    <= addr + 1'b1;
      end
    end
  end

  // byte holding, payload only
  always_ff @(posedge hwclk) begin
    if (rxReady_i && accept_i && !haveHigh) begin
      highByte <= rxData_i;
    end
    if (rxReady_i && accept_i && haveHigh) begin
      wordReg <= {highByte, rxData_i};
    end
  end

  // write request held until ack
  assign loadReq_o  = pending;
  assign loadDone_o = pending & ack_i;
  assign req_o = '{cyc: pending, stb: pending, we: 1'b1, sel: 2'b11, adr: addr, dat: wordReg};

endmodule

// ==== design/clockDivider.sv ====
`timescale 1ns/10ps

module clockDivider #(
  parameter int divideRatio = tftPkg::DIVIDE_DEFAULT
) (
  input  logic hwclk,
  input  logic reset,
  output logic tick_o
);

  // counter wide enough for divideRatio - 1
  localparam int cntWidth = (divideRatio > 1) ? $clog2(divideRatio) : 1;
  localparam logic [cntWidth-1:0] lastCount = cntWidth'(divideRatio - 1);

  logic [cntWidth-1:0] count;

  // wraps at lastCount, tick on the wrap cycle
  always_ff @(posedge hwclk, negedge reset) begin
    if (!reset) begin
      count <= '0;
    end else if (count == lastCount) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // one hwclk wide enable for the serializer
  assign tick_o = (count == lastCount);

endmodule

// ==== design/drawSequencer.sv ====
`timescale 1ns/10ps

module drawSequencer (
  input  logic                hwclk,
  input  logic                reset,
  input  logic                start_i,
  input  logic                loadReq_i,
  input  tftPkg::busReq_t     loadReq_s,
  input  logic                ack_i,
  input  tftPkg::cmdWord_t    rdData_i,
  input  logic                busy_i,
  output logic                loadAccept_o,
  output logic                loadRestart_o,
  output tftPkg::busReq_t     req_o,
  output logic                send_o,
  output tftPkg::cmdWord_t    word_o,
  output logic                done_o,
  output tftPkg::wordCount_t  sentCount_o
);

  import tftPkg::*;

  seqState_t  state;
  seqState_t  nextState;
  logic       startPrev;
  logic       beginPlay;
  wordCount_t idx;
  wordCount_t listLen;

  // button edge, only taken between loader writes
  assign beginPlay = (state == idleLoad) && start_i && !startPrev && !loadReq_i;

  always_comb begin
    nextState = state;
    case (state)
      idleLoad:    if (beginPlay) nextState = fetchLength;
      fetchLength: nextState = waitAck;
      fetchWord:   nextState = waitAck;
      waitAck: begin
        if (ack_i && idx == '0) begin
          // empty list goes straight to done
          nextState = (wordCount_t'(rdData_i) == '0) ? finish : fetchWord;
        end else if (ack_i) begin
          nextState = startShift;
        end
      end
      startShift:  nextState = waitShift;
      // busy already high on entry
      waitShift:   if (!busy_i) nextState = (idx == listLen) ? finish : fetchWord;
      finish:      nextState = idleLoad;
      default:     nextState = idleLoad;
    endcase
  end

  always_ff @(posedge hwclk, negedge reset) begin
    if (!reset) begin
      state       <= idleLoad;
      startPrev   <= 1'b0;
      idx         <= '0;
      listLen     <= '0;
      done_o      <= 1'b0;
      sentCount_o <= '0;
    end else begin
      state     <= nextState;
      startPrev <= start_i;
      if (beginPlay) begin
        done_o      <= 1'b0;
        sentCount_o <= '0;
      end
      if (state == fetchLength) begin
        idx <= '0;
      end
      // word 0 holds the list length
      if (state == waitAck && ack_i && idx == '0) begin
        listLen <= wordCount_t'(rdData_i);
        idx     <= 8'd1;
      end
      if (state == waitShift && !busy_i) begin
        sentCount_o <= sentCount_o + 1'b1;
        if (idx != listLen) begin
          idx <= idx + 1'b1;
        end
      end
      if (state == finish) begin
        done_o <= 1'b1;
      end
    end
  end

  // command word latched from the read
  always_ff @(posedge hwclk) begin
    if (state == waitAck && ack_i && idx != '0) begin
      word_o <= rdData_i;
    end
  end

  // loader owns the bus only while idle
  always_comb begin
    req_o = '0;
    if (state == idleLoad && loadReq_i) begin
      req_o = loadReq_s;
    end else if (state == waitAck) begin
      req_o = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, sel: 2'b11, adr: sramAddr_t'(idx), dat: '0};
    end
  end

  assign loadAccept_o  = (state == idleLoad);
  assign loadRestart_o = beginPlay;
  assign send_o        = (state == startShift);

endmodule

// ==== design/spiTftSerializer.sv ====
`timescale 1ns/10ps

module spiTftSerializer (
  input  logic             hwclk,
  input  logic             reset,
  input  logic             tick_i,
  input  logic             send_i,
  input  tftPkg::cmdWord_t word_i,
  output logic             busy_o,
  output logic             chipSelect_o,
  output logic             sclk_o,
  output logic             bitData_o
);

  import tftPkg::*;

  cmdWord_t   shiftReg;
  // bits already clocked out, 16 means frame body done
  logic [4:0] bitCnt;

  always_ff @(posedge hwclk, negedge reset) begin
    if (!reset) begin
      busy_o       <= 1'b0;
      chipSelect_o <= 1'b1;
      sclk_o       <= 1'b0;
      bitCnt       <= '0;
      shiftReg     <= '0;
    end else if (!busy_o) begin
      // send while busy never reaches here
      if (send_i) begin
        busy_o   <= 1'b1;
        bitCnt   <= '0;
        shiftReg <= word_i;
      end
    end else if (tick_i) begin
      if (chipSelect_o) begin
        // open the frame, MSB already on the line
        chipSelect_o <= 1'b0;
      end else if (bitCnt == 5'd16) begin
        // close one tick after the last bit
        chipSelect_o <= 1'b1;
        busy_o       <= 1'b0;
      end else if (!sclk_o) begin
        // panel samples here
        sclk_o <= 1'b1;
      end else begin
        // falling edge, next bit out
        sclk_o   <= 1'b0;
        bitCnt   <= bitCnt + 1'b1;
        shiftReg <= {shiftReg[14:0], 1'b0};
      end
    end
  end

  // MSB first
  assign bitData_o = shiftReg[15];

endmodule

// ==== design/tftBoardTop.sv ====
`timescale 1ns/10ps

module tftBoardTop #(
  parameter int divideRatio = tftPkg::DIVIDE_DEFAULT
) (
  input  logic        hwclk,
  input  logic        reset,
  input  logic [20:0] pb,
  output logic [7:0]  left,
  output logic [7:0]  right,
  output logic [7:0]  ss7, ss6, ss5, ss4, ss3, ss2, ss1, ss0,
  output logic        red,
  output logic        green,
  output logic        blue,
  output logic [7:0]  txdata,
  input  logic [7:0]  rxdata,
  output logic        txclk,
  output logic        rxclk,
  input  logic        txready,
  input  logic        rxready
);

  import tftPkg::*;

  logic     tick;
  logic     loadReq, loadAccept, loadRestart, loadDone;
  busReq_t  loadBus, busReq;
  logic     ack;
  cmdWord_t rdData;
  logic     send, busy;
  cmdWord_t word;

  clockDivider #(.divideRatio(divideRatio)) u_clockDivider (
    .hwclk(hwclk), .reset(reset), .tick_o(tick));

  byteLoader u_byteLoader (
    .hwclk(hwclk), .reset(reset), .rxReady_i(rxready), .rxData_i(rxdata),
    .restart_i(loadRestart), .accept_i(loadAccept), .ack_i(ack),
    .loadReq_o(loadReq), .req_o(loadBus), .loadDone_o(loadDone), .overrun_o(red));

  wbSram u_wbSram (
    .hwclk(hwclk), .reset(reset), .req_i(busReq), .ack_o(ack), .rdData_o(rdData));

  // panel pins on right[3:1], busy on right[7]
  spiTftSerializer u_spiTftSerializer (
    .hwclk(hwclk), .reset(reset), .tick_i(tick), .send_i(send), .word_i(word),
    .busy_o(busy), .chipSelect_o(right[3]), .sclk_o(right[2]), .bitData_o(right[1]));

  drawSequencer u_drawSequencer (
    .hwclk(hwclk), .reset(reset), .start_i(pb[0]), .loadReq_i(loadReq),
    .loadReq_s(loadBus), .ack_i(ack), .rdData_i(rdData), .busy_i(busy),
    .loadAccept_o(loadAccept), .loadRestart_o(loadRestart), .req_o(busReq),
    .send_o(send), .word_o(word), .done_o(green), .sentCount_o(left));

  // flashes per stored word
  assign right[0]   = loadDone;
  assign right[7]   = busy;
  assign right[6:4] = '0;
  // no seven segment content
  assign {ss7, ss6, ss5, ss4, ss3, ss2, ss1, ss0} = '0;
  assign blue   = 1'b0;
  // no UART transmit
  assign txdata = '0;
  assign txclk  = 1'b0;
  assign rxclk  = 1'b0;

endmodule

// ==== design/tftPkg.sv ====
package tftPkg;

  // default hwclk cycles per SPI tick
  // 40 keeps the panel clock of the old derived clock
  parameter int DIVIDE_DEFAULT = 40;

  // one TFT command or data word
  typedef logic [15:0] cmdWord_t;

  // word address into the command SRAM
  // 256 words deep
  typedef logic [7:0] sramAddr_t;

  // list length and sent word count
  typedef logic [7:0] wordCount_t;

  // single-beat wishbone request, 29 bits
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    logic [1:0] sel;
    sramAddr_t adr;
    cmdWord_t  dat;
  } busReq_t;

  // playback control states
  typedef enum logic [2:0] {
    idleLoad,
    fetchLength,
    fetchWord,
    waitAck,
    startShift,
    waitShift,
    finish
  } seqState_t;

endpackage

// ==== design/wbSram.sv ====
`timescale 1ns/10ps

module wbSram (
  input  logic             hwclk,
  input  logic             reset,
  input  tftPkg::busReq_t  req_i,
  output logic             ack_o,
  output tftPkg::cmdWord_t rdData_o
);

  import tftPkg::*;

  // depth follows the address type
  localparam int depth = 2 ** $bits(sramAddr_t);

  cmdWord_t mem [depth];

  logic served;
  logic accessStart;

  // first cycle of a request not yet answered
  assign accessStart = req_i.cyc & req_i.stb & !ack_o & !served;

  always_ff @(posedge hwclk, negedge reset) begin
    if (!reset) begin
      ack_o  <= 1'b0;
      served <= 1'b0;
    end else begin
      ack_o <= accessStart;
      // blocks a second ack while stb lingers
      if (!req_i.stb) begin
        served <= 1'b0;
      end else if (ack_o) begin
        served <= 1'b1;
      end
    end
  end

  // byte lane writes
  always_ff @(posedge hwclk) begin
    if (accessStart && req_i.we) begin
      if (req_i.sel[1]) begin
        mem[req_i.adr][15:8] <= req_i.dat[15:8];
      end
      if (req_i.sel[0]) begin
        mem[req_i.adr][7:0] <= req_i.dat[7:0];
      end
    end
  end

  // read data lands with ack
  always_ff @(posedge hwclk) begin
    if (accessStart) begin
      rdData_o <= mem[req_i.adr];
    end
  end

endmodule

// ==== tftBoardTop.f ====
design/tftPkg.sv
design/clockDivider.sv
design/byteLoader.sv
design/wbSram.sv
design/spiTftSerializer.sv
design/drawSequencer.sv
design/tftBoardTop.sv
bench/tftBoardTop_properties.sv
bench/tftBoardTop_tb.sv
